// File: list.f
+incdir+source
source/amo_pkg.sv
source/amo_decoder.sv
source/amo_alu.sv
source/amo_sequencer.sv
source/amo_adapter.sv
testbench/tb_mem_model.sv
testbench/tb_amo_adapter.sv

// File: run.sh
#!/bin/sh
# Builds and runs the atomic adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_amo_adapter -f list.f -Mdir obj_dir -o tb_amo_adapter
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/tb_amo_adapter)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^sim passed$"; then
    exit 0
fi
exit 1

// File: testbench/tb_amo_adapter.sv
// Atomic adapter testbench

`default_nettype none

`include "amo_consts.svh"

module tb_amo_adapter
    import amo_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h261d_922b;
    localparam int NUM_DIRECTED = 37;
    localparam int NUM_RANDOM   = 160;
    localparam int NUM_REQ      = NUM_DIRECTED + NUM_RANDOM;
    localparam int CYCLE_LIMIT  = 60 * NUM_REQ + 16;

    typedef struct packed {
        amo_rsp_t    rsp;
        logic [5:0]  idx;
        logic [63:0] word;
    } expect_t;

    logic        clk;
    logic        rst_n;
    amo_req_t    req;
    logic        req_valid;
    logic        req_ready;
    amo_rsp_t    rsp;
    logic        rsp_valid;
    logic        rsp_ready = 1'b0;
    mem_req_t    mem_req;
    logic        mem_req_valid;
    logic        mem_req_ready;
    logic [63:0] mem_rdata;
    logic        mem_rvalid;

    logic [31:0] stim_state = SEED;
    logic [31:0] bp_state   = SEED ^ 32'hffff_0000;
    logic [31:0] mem_rnd    = SEED ^ 32'h5555_aaaa;
    logic [63:0] shadow [64];
    expect_t     exp_q [$];
    int          cycles   = 0;
    int          sent     = 0;
    int          received = 0;

    amo_adapter dut_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .rsp_o           (rsp),
        .rsp_valid_o     (rsp_valid),
        .rsp_ready_i     (rsp_ready),
        .mem_req_o       (mem_req),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_rdata_i     (mem_rdata),
        .mem_rvalid_i    (mem_rvalid)
    );

    tb_mem_model mem_i (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .rnd_i           (mem_rnd),
        .mem_req_i       (mem_req),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_rdata_o     (mem_rdata),
        .mem_rvalid_o    (mem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    function automatic amo_class_e classify(input amo_req_t r);
        if (r.amo.raw == 6'h00) return CLASS_PLAIN;
        if (!r.we || r.size != `AMO_WORD_SIZE) return CLASS_INVALID;
        if (r.amo.raw == `AMO_SWAP) return CLASS_LOAD;
        // Big-endian flag
        if (r.amo.raw[3]) return CLASS_INVALID;
        if (r.amo.raw[5:4] == `AMO_KIND_LOAD) return CLASS_LOAD;
        if (r.amo.raw[5:4] == `AMO_KIND_STORE) return CLASS_STORE;
        return CLASS_INVALID;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [5:0] code, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (code == `AMO_SWAP) return b;
        case (code[2:0])
            `AMO_OP_ADD:  return a + b;
            `AMO_OP_CLR:  return a & ~b;
            `AMO_OP_EOR:  return a ^ b;
            `AMO_OP_SET:  return a | b;
            `AMO_OP_SMAX: return (sa > sb) ? a : b;
            `AMO_OP_SMIN: return (sa < sb) ? a : b;
            `AMO_OP_UMAX: return (a > b) ? a : b;
            default:      return (a < b) ? a : b;
        endcase
    endfunction

    // Expected response and new memory word for one request
    function automatic amo_rsp_t model_req(input amo_req_t r, input amo_class_e cls,
                                           input logic [63:0] old, output logic [63:0] new_word);
        amo_rsp_t    exp;
        logic [63:0] mask;
        logic [63:0] merged;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            mask[8*i +: 8] = r.strb[i] ? 8'hff : 8'h00;
        end
        exp.id   = r.id;
        exp.resp = `AMO_RESP_OKAY;
        exp.data = '0;
        new_word = old;
        if (cls == CLASS_INVALID) begin
            exp.data = '1;
            exp.resp = `AMO_RESP_SLVERR;
        end else if (cls == CLASS_PLAIN) begin
            if (r.we) begin
                new_word = (old & ~mask) | (r.data & mask);
            end else begin
                exp.data = old;
            end
        end else begin
            a        = 32'((old & mask) >> (r.addr[2] ? 32 : 0));
            b        = 32'((r.data & mask) >> (r.addr[2] ? 32 : 0));
            merged   = {32'h0, alu_ref(r.amo.raw, a, b)} << (r.addr[2] ? 32 : 0);
            new_word = (old & ~mask) | (merged & mask);
            if (cls == CLASS_LOAD) begin
                exp.data = old;
            end
        end
        return exp;
    endfunction

    function automatic amo_req_t atomic_req(input logic [5:0] code, input logic [5:0] idx,
                                            input logic lane);
        amo_req_t r;
        r         = '0;
        r.addr    = {7'd0, idx, lane, 2'b00};
        r.we      = 1'b1;
        r.size    = `AMO_WORD_SIZE;
        r.amo.raw = code;
        r.data    = {rand32(), rand32()};
        r.strb    = lane ? 8'hf0 : 8'h0f;
        return r;
    endfunction

    task automatic check_rsp(input amo_rsp_t exp, input amo_rsp_t act);
        if (act !== exp) begin
            $display("** Error rsp_o: expected id %h data %h resp %h, got id %h data %h resp %h",
                     exp.id, exp.data, exp.resp, act.id, act.data, act.resp);
            $display("sim failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_word(input logic [5:0] idx, input logic [63:0] exp,
                              input logic [63:0] act);
        if (act !== exp) begin
            $display("** Error mem_i.words[%0d]: expected %h, got %h", idx, exp, act);
            $display("sim failed");
            $fatal(1, "memory mismatch");
        end
    endtask

    // Queue the expected result, then hold the request until accepted
    task automatic send_req(input amo_req_t r);
        expect_t     e;
        amo_class_e  cls;
        logic [63:0] new_word;
        r.id   = sent[3:0];
        cls    = classify(r);
        e.idx  = r.addr[8:3];
        e.rsp  = model_req(r, cls, shadow[e.idx], new_word);
        e.word = new_word;
        shadow[e.idx] = new_word;
        exp_q.push_back(e);
        req       = r;
        req_valid = 1'b1;
        // A high ready at the falling edge means accept at the next rising edge
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        sent++;
        req_valid = 1'b0;
        if (cls == CLASS_INVALID && !rsp_valid) begin
            $display("Error response for id %h was not valid one cycle after accept", r.id);
            $display("sim failed");
            $fatal(1, "late error response");
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, received, NUM_REQ);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    // Back-pressure on the response channel
    always @(negedge clk) begin
        bp_state  = lcg_step(bp_state);
        rsp_ready = (bp_state[31:30] != 2'b00);
    end

    always @(posedge clk) begin
        mem_rnd <= lcg_step(mem_rnd);
    end

    always @(posedge clk) begin
        expect_t head;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response with id %h arrived with no request outstanding", rsp.id);
                $display("sim failed");
                $fatal(1, "unexpected response");
            end else begin
                head = exp_q.pop_front();
                check_rsp(head.rsp, rsp);
                check_word(head.idx, head.word, mem_i.words[head.idx]);
                received <= received + 1;
            end
        end
    end

    initial begin
        amo_req_t    r;
        logic [31:0] rnd;
        logic [5:0]  code;
        req       = '0;
        req_valid = 1'b0;
        rst_n     = 1'b1;
        #1 rst_n  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (!req_ready || rsp_valid || mem_req_valid) begin
            $display("Handshake outputs were not idle after reset");
            $display("sim failed");
            $fatal(1, "bad reset state");
        end
        for (int i = 0; i < 64; i++) begin
            shadow[i] = mem_i.words[i];
        end

        // Plain writes with random strobes, then read back
        for (int i = 0; i < 8; i++) begin
            rnd    = rand32();
            r      = '0;
            r.addr = 16'(64 + 8 * i);
            r.we   = 1'b1;
            r.size = 3'd3;
            r.data = {rand32(), rand32()};
            r.strb = rnd[7:0];
            send_req(r);
        end
        for (int i = 0; i < 8; i++) begin
            r      = '0;
            r.addr = 16'(64 + 8 * i);
            r.size = 3'd3;
            send_req(r);
        end

        for (int i = 0; i < 8; i++) begin
            send_req(atomic_req({`AMO_KIND_LOAD, 1'b0, 3'(i)}, 6'(16 + i), i[0]));
        end
        send_req(atomic_req(`AMO_SWAP, 6'd24, 1'b1));
        for (int i = 0; i < 8; i++) begin
            send_req(atomic_req({`AMO_KIND_STORE, 1'b0, 3'(i)}, 6'(32 + i), ~i[0]));
        end

        // Compare-and-swap, big-endian, read and wrong size
        send_req(atomic_req(6'h31, 6'd40, 1'b0));
        send_req(atomic_req(6'h2c, 6'd41, 1'b1));
        r    = atomic_req(6'h20, 6'd42, 1'b0);
        r.we = 1'b0;
        send_req(r);
        r      = atomic_req(6'h22, 6'd43, 1'b1);
        r.size = 3'd3;
        send_req(r);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = rand32();
            if (rnd[31:30] == 2'b00) begin
                r      = '0;
                r.addr = {7'd0, rnd[21:16], rnd[15], 2'b00};
                r.we   = rnd[29];
                r.size = 3'd3;
                r.data = {rand32(), rand32()};
                r.strb = rnd[7:0];
            end else begin
                code = {rnd[29:28], rnd[27:26] == 2'b11, rnd[25:23]};
                if (code[5:4] == 2'b11 && rnd[22]) begin
                    code = `AMO_SWAP;
                end
                r = atomic_req(code, rnd[21:16], rnd[15]);
                // Now and then odd strobes, a read or a wrong size
                if (rnd[14:12] == 3'd0) r.strb = rnd[7:0];
                if (rnd[11:9] == 3'd0) r.we = 1'b0;
                if (rnd[8:6] == 3'd0) r.size = 3'd3;
            end
            send_req(r);
        end

        wait (received == sent);
        repeat (4) @(posedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
// Memory model with random stalls

`default_nettype none

`include "amo_consts.svh"

module tb_mem_model
    import amo_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [31:0]                rnd_i,
    input  mem_req_t                   mem_req_i,
    input  logic                       mem_req_valid_i,
    output logic                       mem_req_ready_o,
    output logic [`AMO_DATA_WIDTH-1:0] mem_rdata_o,
    output logic                       mem_rvalid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`AMO_DATA_WIDTH-1:0] words [64];
    logic [5:0]                 rd_idx;
    // Cycles left until the read data is shown, 0 when no read is open
    logic [2:0]                 rd_wait;

    initial begin
        for (int i = 0; i < 64; i++) begin
            words[i] = {32'(i) * 32'h9e37_79b9 ^ 32'hc0de_0000, ~(32'(i) * 32'h0101_0101)};
        end
    end

    always @(posedge clk_i) begin
        if (mem_req_valid_i && mem_req_ready_o && mem_req_i.we) begin
            for (int b = 0; b < 8; b++) begin
                if (mem_req_i.strb[b]) begin
                    words[mem_req_i.addr[8:3]][8*b +: 8] <= mem_req_i.data[8*b +: 8];
                end
            end
        end
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_wait <= 3'd0;
            rd_idx  <= '0;
        end else if (mem_req_valid_i && mem_req_ready_o && !mem_req_i.we) begin
            rd_idx  <= mem_req_i.addr[8:3];
            rd_wait <= {1'b0, rnd_i[29:28]} + 3'd1;
        end else if (rd_wait != 3'd0) begin
            rd_wait <= rd_wait - 3'd1;
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_req_ready_o <= 1'b0;
            mem_rvalid_o    <= 1'b0;
            mem_rdata_o     <= '0;
        end else begin
            // Stalls about one cycle in four
            mem_req_ready_o <= (rnd_i[25:24] != 2'b00);
            mem_rvalid_o    <= (rd_wait == 3'd1);
            mem_rdata_o     <= words[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: source/amo_adapter.sv
// Atomic memory operation adapter

`default_nettype none

`include "amo_consts.svh"

module amo_adapter
    import amo_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  amo_req_t                   req_i,
    input  logic                       req_valid_i,
    output logic                       req_ready_o,

    output amo_rsp_t                   rsp_o,
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,

    output mem_req_t                   mem_req_o,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    input  logic [`AMO_DATA_WIDTH-1:0] mem_rdata_i,
    input  logic                       mem_rvalid_i
);

    amo_class_e                 req_class;
    amo_req_t                   alu_req;
    logic [`AMO_DATA_WIDTH-1:0] alu_old;
    logic [`AMO_DATA_WIDTH-1:0] alu_result;

    amo_decoder decoder_i (
        .req_i   (req_i),
        .class_o (req_class)
    );

    amo_sequencer sequencer_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .class_i         (req_class),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rdata_i     (mem_rdata_i),
        .mem_rvalid_i    (mem_rvalid_i),
        .alu_req_o       (alu_req),
        .alu_old_o       (alu_old),
        .alu_result_i    (alu_result)
    );

    amo_alu alu_i (
        .amo_i     (alu_req.amo),
        .addr_i    (alu_req.addr),
        .old_i     (alu_old),
        .operand_i (alu_req.data),
        .strb_i    (alu_req.strb),
        .result_o  (alu_result)
    );

endmodule

`default_nettype wire

// File: source/amo_sequencer.sv
// Transaction sequencer

`default_nettype none

`include "amo_consts.svh"

module amo_sequencer
    import amo_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    input  amo_req_t                   req_i,
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  amo_class_e                 class_i,

    output amo_rsp_t                   rsp_o,
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,

    output mem_req_t                   mem_req_o,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    input  logic [`AMO_DATA_WIDTH-1:0] mem_rdata_i,
    input  logic                       mem_rvalid_i,

    output amo_req_t                   alu_req_o,
    output logic [`AMO_DATA_WIDTH-1:0] alu_old_o,
    input  logic [`AMO_DATA_WIDTH-1:0] alu_result_i
);

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ,
        RESPOND
    } state_e;

    state_e                     state_q, state_d;
    amo_class_e                 class_q;
    amo_req_t                   req_q;
    logic [`AMO_DATA_WIDTH-1:0] rdata_q;
    logic                       accept;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (class_i == CLASS_INVALID) begin
                        // Never touches memory
                        state_d = RESPOND;
                    end else if (class_i == CLASS_PLAIN && req_i.we) begin
                        state_d = WRITE_REQ;
                    end else begin
                        state_d = READ_REQ;
                    end
                end
            end
            READ_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = READ_WAIT;
                end
            end
            READ_WAIT: begin
                if (mem_rvalid_i) begin
                    state_d = (class_q == CLASS_PLAIN) ? RESPOND : WRITE_REQ;
                end
            end
            WRITE_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            class_q <= CLASS_PLAIN;
        end else begin
            state_q <= state_d;
            if (accept) begin
                class_q <= class_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (state_q == READ_WAIT && mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    // Write data comes from the ALU for atomics
    assign mem_req_valid_o = (state_q == READ_REQ) || (state_q == WRITE_REQ);
    assign mem_req_o.we    = (state_q == WRITE_REQ);
    assign mem_req_o.addr  = req_q.addr;
    assign mem_req_o.data  = (class_q == CLASS_PLAIN) ? req_q.data : alu_result_i;
    assign mem_req_o.strb  = req_q.strb;

    assign alu_req_o = req_q;
    assign alu_old_o = rdata_q;

    // Response built from registered state only
    assign rsp_valid_o = (state_q == RESPOND);

    always_comb begin
        rsp_o.id   = req_q.id;
        rsp_o.resp = `AMO_RESP_OKAY;
        case (class_q)
            CLASS_INVALID: begin
                rsp_o.data = '1;
                rsp_o.resp = `AMO_RESP_SLVERR;
            end
            CLASS_STORE: rsp_o.data = '0;
            CLASS_LOAD:  rsp_o.data = rdata_q;
            default:     rsp_o.data = req_q.we ? '0 : rdata_q;
        endcase
    end

    mem_req_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

    rsp_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

    // Read data only returns for the one read in flight
    rvalid_in_wait_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> state_q == READ_WAIT);

endmodule

`default_nettype wire

// File: source/amo_alu.sv
// Atomic ALU on one 32-bit lane

`default_nettype none

`include "amo_consts.svh"

module amo_alu
    import amo_pkg::*;
(
    input  amo_op_u                      amo_i,
    input  logic [`AMO_ADDR_WIDTH-1:0]   addr_i,
    input  logic [`AMO_DATA_WIDTH-1:0]   old_i,
    input  logic [`AMO_DATA_WIDTH-1:0]   operand_i,
    input  logic [`AMO_DATA_WIDTH/8-1:0] strb_i,
    output logic [`AMO_DATA_WIDTH-1:0]   result_o
);

    logic [`AMO_DATA_WIDTH-1:0] strb_ext;
    logic [`AMO_DATA_WIDTH-1:0] old_masked;
    logic [`AMO_DATA_WIDTH-1:0] opd_masked;
    logic [`AMO_WORD_WIDTH-1:0] op_a;
    logic [`AMO_WORD_WIDTH-1:0] op_b;
    logic [`AMO_WORD_WIDTH-1:0] res;
    logic                       lane;

    // Byte strobes to a bit mask
    always_comb begin
        for (int i = 0; i < `AMO_DATA_WIDTH/8; i++) begin
            strb_ext[8*i +: 8] = {8{strb_i[i]}};
        end
    end

    assign old_masked = old_i & strb_ext;
    assign opd_masked = operand_i & strb_ext;

    // Bit 2 selects the upper or lower word of the 64-bit beat
    assign lane = addr_i[2];
    assign op_a = lane ? old_masked[`AMO_DATA_WIDTH-1 -: `AMO_WORD_WIDTH]
                       : old_masked[`AMO_WORD_WIDTH-1:0];
    assign op_b = lane ? opd_masked[`AMO_DATA_WIDTH-1 -: `AMO_WORD_WIDTH]
                       : opd_masked[`AMO_WORD_WIDTH-1:0];

    always_comb begin
        // Swap shares op 0 with add, so it is checked first
        res = op_b;
        if (amo_i.raw != `AMO_SWAP) begin
            case (amo_i.f.op)
                `AMO_OP_ADD:  res = op_a + op_b;
                `AMO_OP_CLR:  res = op_a & ~op_b;
                `AMO_OP_EOR:  res = op_a ^ op_b;
                `AMO_OP_SET:  res = op_a | op_b;
                `AMO_OP_SMAX: res = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
                `AMO_OP_SMIN: res = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
                `AMO_OP_UMAX: res = (op_a > op_b) ? op_a : op_b;
                `AMO_OP_UMIN: res = (op_a < op_b) ? op_a : op_b;
                default:      res = op_b;
            endcase
        end
    end

    // Other lane stays zero, strobes keep it out of memory
    assign result_o = lane ? {res, {`AMO_WORD_WIDTH{1'b0}}}
                           : {{`AMO_WORD_WIDTH{1'b0}}, res};

endmodule

`default_nettype wire

// File: source/amo_decoder.sv
// Request classifier

`default_nettype none

`include "amo_consts.svh"

module amo_decoder
    import amo_pkg::*;
(
    input  amo_req_t   req_i,
    output amo_class_e class_o
);

    always_comb begin
        case (req_i.amo.f.kind)
            `AMO_KIND_NONE: begin
                // Any stray low bits without a kind are rejected
                class_o = (req_i.amo.raw == '0) ? CLASS_PLAIN : CLASS_INVALID;
            end
            `AMO_KIND_LOAD: begin
                class_o = req_i.amo.f.big_endian ? CLASS_INVALID : CLASS_LOAD;
            end
            `AMO_KIND_STORE: begin
                class_o = req_i.amo.f.big_endian ? CLASS_INVALID : CLASS_STORE;
            end
            default: begin
                // Swap returns the old word like a load, compare is unsupported
                class_o = (req_i.amo.raw == `AMO_SWAP) ? CLASS_LOAD : CLASS_INVALID;
            end
        endcase

        // Atomics must be 32-bit writes
        if (req_i.amo.raw != '0) begin
            if (!req_i.we || req_i.size != `AMO_WORD_SIZE) begin
                class_o = CLASS_INVALID;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/amo_pkg.sv
// Atomic adapter types

`default_nettype none

`include "amo_consts.svh"

package amo_pkg;

    // Opcode split into its fields
    typedef struct packed {
        logic [1:0] kind;
        logic       big_endian;
        logic [2:0] op;
    } amo_op_fields_t;

    // Swap is matched on the whole code, the rest on fields
    typedef union packed {
        logic [5:0]     raw;
        amo_op_fields_t f;
    } amo_op_u;

    typedef enum logic [1:0] {
        CLASS_PLAIN,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_INVALID
    } amo_class_e;

    // Upstream request, amo is zero for plain traffic
    typedef struct packed {
        logic [`AMO_ID_WIDTH-1:0]     id;
        logic [`AMO_ADDR_WIDTH-1:0]   addr;
        logic                         we;
        logic [2:0]                   size;
        amo_op_u                      amo;
        logic [`AMO_DATA_WIDTH-1:0]   data;
        logic [`AMO_DATA_WIDTH/8-1:0] strb;
    } amo_req_t;

    typedef struct packed {
        logic [`AMO_ID_WIDTH-1:0]   id;
        logic [`AMO_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
    } amo_rsp_t;

    typedef struct packed {
        logic                         we;
        logic [`AMO_ADDR_WIDTH-1:0]   addr;
        logic [`AMO_DATA_WIDTH-1:0]   data;
        logic [`AMO_DATA_WIDTH/8-1:0] strb;
    } mem_req_t;

endpackage

`default_nettype wire

// File: source/amo_consts.svh
// Atomic adapter constants

`ifndef AMO_CONSTS_SVH
`define AMO_CONSTS_SVH

`define AMO_ADDR_WIDTH  16
`define AMO_DATA_WIDTH  64
`define AMO_WORD_WIDTH  32
`define AMO_ID_WIDTH    4
`define AMO_WORD_SIZE   3'd2

// Upper two opcode bits, 2'b11 holds swap and compare
`define AMO_KIND_NONE   2'b00
`define AMO_KIND_STORE  2'b01
`define AMO_KIND_LOAD   2'b10

// Lower three opcode bits
`define AMO_OP_ADD      3'd0
`define AMO_OP_CLR      3'd1
`define AMO_OP_EOR      3'd2
`define AMO_OP_SET      3'd3
`define AMO_OP_SMAX     3'd4
`define AMO_OP_SMIN     3'd5
`define AMO_OP_UMAX     3'd6
`define AMO_OP_UMIN     3'd7

`define AMO_SWAP        6'h30

`define AMO_RESP_OKAY   2'd0
`define AMO_RESP_SLVERR 2'd2

`endif
